// File: flist.f
hw/id_pkg.sv
hw/rvc_expander.sv
hw/instr_decoder.sv
hw/issue_register.sv
hw/id_stage.sv
verification/tb_clock_gen.sv
verification/id_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/id_stage_tb.sv
// --------------------------------------------------
// ID stage testbench
// Table-driven decode checks with random fetch valids,
// random acks, back-pressure and flush
// --------------------------------------------------

`timescale 1ns/1ps

module id_stage_tb;

  import id_pkg::*;

  localparam int NumRows       = 20;
  localparam int TimeoutCycles = 2000;

  typedef struct packed {
    instr_t    instr;
    fu_t       fu;
    op_t       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    imm_t      imm;
    logic [2:0] flags;  // illegal, is_compressed, is_ctrl_flow
    instr_t    orig;
  } row_t;

  logic clk;
  logic rst_n;
  logic flush;
  fetch_entry_t   [1:0] fetch_entry;
  logic           [1:0] fetch_valid;
  logic           [1:0] fetch_ready;
  decoded_instr_t [1:0] issue_entry;
  instr_t         [1:0] orig_instr;
  logic           [1:0] issue_valid;
  logic           [1:0] issue_ack;
  logic           [1:0] ack_req;
  logic           [1:0] valid_seen;

  row_t rows [NumRows];
  int   seed = 32'h9bbd1215;
  int   sent_idx;
  int   exp_idx;
  int   errors;
  int   checks;
  int   tests_ok;
  int   tests_failed;
  int   errs_before;
  int   cyc;
  bit   timed_out;

  tb_clock_gen u_clock_gen (.clk_o(clk), .rst_no(rst_n));

  id_stage dut (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .flush_i            (flush),
    .fetch_entry_i      (fetch_entry),
    .fetch_entry_valid_i(fetch_valid),
    .fetch_entry_ready_o(fetch_ready),
    .issue_entry_o      (issue_entry),
    .orig_instr_o       (orig_instr),
    .issue_entry_valid_o(issue_valid),
    .issue_ack_i        (issue_ack)
  );

  // Issue stage model where port 1 retires only together with port 0
  assign issue_ack[0] = ack_req[0] & issue_valid[0];
  assign issue_ack[1] = ack_req[1] & ack_req[0] & issue_valid[1] & issue_valid[0];

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic finish_test(input string name);
    if (errors == errs_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
    errs_before = errors;
  endtask

  // Compare one acknowledged output with the next row in program order
  task automatic score_entry(input int k);
    row_t r;
    if (exp_idx >= NumRows) begin
      $display("Port %0d issued an entry past the end of the table", k);
      errors++;
    end else begin
      r = rows[exp_idx];
      check_value("issue_entry_o.pc", issue_entry[k].pc, 32'(exp_idx * 4));
      check_value("issue_entry_o.fu", 32'(issue_entry[k].fu), 32'(r.fu));
      check_value("issue_entry_o.op", 32'(issue_entry[k].op), 32'(r.op));
      check_value("issue_entry_o.rd", 32'(issue_entry[k].rd), 32'(r.rd));
      check_value("issue_entry_o.rs1", 32'(issue_entry[k].rs1), 32'(r.rs1));
      check_value("issue_entry_o.rs2", 32'(issue_entry[k].rs2), 32'(r.rs2));
      check_value("issue_entry_o.imm", issue_entry[k].imm, r.imm);
      check_value("issue_entry_o.illegal", 32'(issue_entry[k].illegal), 32'(r.flags[2]));
      check_value("issue_entry_o.is_compressed", 32'(issue_entry[k].is_compressed),
                  32'(r.flags[1]));
      check_value("issue_entry_o.is_ctrl_flow", 32'(issue_entry[k].is_ctrl_flow),
                  32'(r.flags[0]));
      check_value("orig_instr_o", orig_instr[k], r.orig);
      exp_idx++;
    end
  endtask

  function automatic fetch_entry_t make_entry(input int idx);
    fetch_entry_t e;
    e.address     = 32'(idx * 4);
    e.instruction = (idx < NumRows) ? rows[idx].instr : 32'h0;
    return e;
  endfunction

  // Sample at the falling edge, drive at the rising edge
  task automatic cycle_step(input bit feed_en, input bit feed_all, input bit ack_en);
    logic [1:0] take;
    int         r;
    @(negedge clk);
    valid_seen = issue_valid;
    for (int k = 0; k < 2; k++) begin
      if (issue_valid[k] && issue_ack[k]) score_entry(k);
    end
    if (issue_valid == 2'b11 && issue_ack == 2'b00) begin
      check_value("fetch_entry_ready_o", 32'(fetch_ready), 32'h0);
    end
    check_value("fetch_entry_ready_o & ~valid", 32'(fetch_ready & ~fetch_valid), 32'h0);
    take = fetch_ready & fetch_valid;
    if (take[0]) sent_idx++;
    if (take[1]) sent_idx++;
    @(posedge clk);
    r = $random(seed);
    fetch_valid[0] <= feed_en && (sent_idx < NumRows) && (feed_all || r[0]);
    fetch_valid[1] <= feed_en && (sent_idx + 1 < NumRows) && (feed_all || r[1]);
    fetch_entry[0] <= make_entry(sent_idx);
    fetch_entry[1] <= make_entry(sent_idx + 1);
    ack_req        <= ack_en ? r[3:2] : 2'b00;
  endtask

  initial begin
    flush       = 1'b0;
    fetch_entry = '0;
    fetch_valid = '0;
    ack_req     = '0;

    // Fetched word, fu, op, rd, rs1, rs2, imm, flags, orig_instr
    rows[0]  = '{32'h123452B7, FU_ALU, 4'h0, 5'd5, 5'd0, 5'd0, 32'h12345000, 3'b000, 32'h123452B7};
    rows[1]  = '{32'h00001097, FU_ALU, 4'h0, 5'd1, 5'd0, 5'd0, 32'h00001000, 3'b000, 32'h00001097};
    rows[2]  = '{32'h008000EF, FU_BRANCH, 4'h0, 5'd1, 5'd0, 5'd0, 32'h8, 3'b001, 32'h008000EF};
    rows[3]  = '{32'h00008067, FU_BRANCH, 4'h0, 5'd0, 5'd1, 5'd0, 32'h0, 3'b001, 32'h00008067};
    rows[4]  = '{32'h00208863, FU_BRANCH, 4'h0, 5'd0, 5'd1, 5'd2, 32'h10, 3'b001, 32'h00208863};
    rows[5]  = '{32'hFFC12183, FU_LOAD, 4'h2, 5'd3, 5'd2, 5'd0, 32'hFFFFFFFC, 3'b000, 32'hFFC12183};
    rows[6]  = '{32'h00312423, FU_STORE, 4'h2, 5'd0, 5'd2, 5'd3, 32'h8, 3'b000, 32'h00312423};
    rows[7]  = '{32'h4032D213, FU_ALU, 4'hD, 5'd4, 5'd5, 5'd0, 32'h403, 3'b000, 32'h4032D213};
    rows[8]  = '{32'h40838333, FU_ALU, 4'h8, 5'd6, 5'd7, 5'd8, 32'h0, 3'b000, 32'h40838333};
    rows[9]  = '{32'h0000007F, FU_NONE, 4'h0, 5'd0, 5'd0, 5'd0, 32'h0, 3'b100, 32'h0000007F};
    // Compressed rows
    // The upper half of row 10 must not reach orig_instr
    rows[10] = '{32'hDEAD0515, FU_ALU, 4'h0, 5'd10, 5'd10, 5'd0, 32'h5, 3'b010, 32'h0515};
    rows[11] = '{32'h000055FD, FU_ALU, 4'h0, 5'd11, 5'd0, 5'd0, 32'hFFFFFFFF, 3'b010, 32'h55FD};
    rows[12] = '{32'h00008636, FU_ALU, 4'h0, 5'd12, 5'd0, 5'd13, 32'h0, 3'b010, 32'h8636};
    rows[13] = '{32'h00009636, FU_ALU, 4'h0, 5'd12, 5'd12, 5'd13, 32'h0, 3'b010, 32'h9636};
    rows[14] = '{32'h0000A011, FU_BRANCH, 4'h0, 5'd0, 5'd0, 5'd0, 32'h4, 3'b011, 32'hA011};
    rows[15] = '{32'h0000C401, FU_BRANCH, 4'h0, 5'd0, 5'd8, 5'd0, 32'h8, 3'b011, 32'hC401};
    rows[16] = '{32'h0000E089, FU_BRANCH, 4'h1, 5'd0, 5'd9, 5'd0, 32'h2, 3'b011, 32'hE089};
    rows[17] = '{32'h00004144, FU_LOAD, 4'h2, 5'd9, 5'd10, 5'd0, 32'h4, 3'b010, 32'h4144};
    rows[18] = '{32'h0000C504, FU_STORE, 4'h2, 5'd0, 5'd10, 5'd9, 32'h8, 3'b010, 32'hC504};
    rows[19] = '{32'h00000000, FU_NONE, 4'h0, 5'd0, 5'd0, 5'd0, 32'h0, 3'b110, 32'h0};

    for (cyc = 0; cyc < TimeoutCycles && rst_n !== 1'b1; cyc++) @(posedge clk);
    if (rst_n !== 1'b1) report_timeout("reset release");
    @(negedge clk);
    check_value("issue_entry_valid_o", 32'(issue_valid), 32'h0);
    check_value("fetch_entry_ready_o", 32'(fetch_ready), 32'h0);
    finish_test("reset");

    // Whole table under random valids and acks
    for (cyc = 0; cyc < TimeoutCycles && exp_idx < NumRows && !timed_out; cyc++) begin
      cycle_step(1'b1, 1'b0, 1'b1);
    end
    if (exp_idx < NumRows) report_timeout("the table to drain");
    // Nothing may be left once every row has issued
    @(negedge clk);
    check_value("issue_entry_valid_o", 32'(issue_valid), 32'h0);
    finish_test("decode_order");

    // Second pass fills both slots without acks and then flushes
    sent_idx   = 0;
    exp_idx    = 0;
    valid_seen = '0;
    for (cyc = 0; cyc < TimeoutCycles && valid_seen != 2'b11 && !timed_out; cyc++) begin
      cycle_step(1'b1, 1'b1, 1'b0);
    end
    if (valid_seen != 2'b11) report_timeout("both slots to fill");
    cycle_step(1'b0, 1'b0, 1'b0);
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    check_value("issue_entry_valid_o", 32'(issue_valid), 32'h0);
    exp_idx = sent_idx;
    finish_test("flush");

    for (cyc = 0; cyc < TimeoutCycles && exp_idx < NumRows && !timed_out; cyc++) begin
      cycle_step(1'b1, 1'b0, 1'b1);
    end
    if (exp_idx < NumRows) report_timeout("the rows after the flush");
    finish_test("resume");

    $display("tests: %0d ok, %0d failed, %0d checks, %0d errors",
             tests_ok, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verification/tb_clock_gen.sv
// --------------------------------------------------
// Testbench clock and reset
// 20 ns clock, active-low reset held for 4 cycles
// --------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned PeriodNs    = 20;
  localparam int unsigned ResetCycles = 4;

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: hw/id_stage.sv
// --------------------------------------------------
// Instruction decode stage
// Expands, decodes and registers two fetch ports
// --------------------------------------------------

`timescale 1ns/1ps

module id_stage (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                flush_i,
  input  id_pkg::fetch_entry_t   [id_pkg::NrIssuePorts-1:0] fetch_entry_i,
  input  logic                   [id_pkg::NrIssuePorts-1:0] fetch_entry_valid_i,
  output logic                   [id_pkg::NrIssuePorts-1:0] fetch_entry_ready_o,
  output id_pkg::decoded_instr_t [id_pkg::NrIssuePorts-1:0] issue_entry_o,
  output id_pkg::instr_t         [id_pkg::NrIssuePorts-1:0] orig_instr_o,
  output logic                   [id_pkg::NrIssuePorts-1:0] issue_entry_valid_o,
  input  logic                   [id_pkg::NrIssuePorts-1:0] issue_ack_i
);

  import id_pkg::*;

  instr_t         [NrIssuePorts-1:0] expanded;
  logic           [NrIssuePorts-1:0] is_compressed;
  logic           [NrIssuePorts-1:0] rvc_illegal;
  decoded_instr_t [NrIssuePorts-1:0] decoded;
  instr_t         [NrIssuePorts-1:0] orig_instr;
  issue_slot_t    [NrIssuePorts-1:0] slot;

  for (genvar i = 0; i < NrIssuePorts; i++) begin : gen_port
    rvc_expander u_rvc_expander (
      .instr_i        (fetch_entry_i[i].instruction),
      .instr_o        (expanded[i]),
      .is_compressed_o(is_compressed[i]),
      .illegal_o      (rvc_illegal[i])
    );

    instr_decoder u_instr_decoder (
      .pc_i           (fetch_entry_i[i].address),
      .instr_i        (expanded[i]),
      .is_compressed_i(is_compressed[i]),
      .illegal_i      (rvc_illegal[i]),
      .entry_o        (decoded[i])
    );

    // Compressed words keep only their 16 bits
    assign orig_instr[i] = is_compressed[i] ?
                           {16'b0, fetch_entry_i[i].instruction[15:0]} :
                           fetch_entry_i[i].instruction;

    assign issue_entry_o[i]       = slot[i].decoded;
    assign orig_instr_o[i]        = slot[i].orig_instr;
    assign issue_entry_valid_o[i] = slot[i].valid;
  end

  issue_register u_issue_register (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .decoded_i    (decoded),
    .orig_instr_i (orig_instr),
    .fetch_valid_i(fetch_entry_valid_i),
    .fetch_ready_o(fetch_entry_ready_o),
    .slot_o       (slot),
    .ack_i        (issue_ack_i)
  );

endmodule

// File: hw/issue_register.sv
// --------------------------------------------------
// ID/issue register
// Two in-order slots between decode and issue, with
// compaction, fetch ready and flush
// --------------------------------------------------

`timescale 1ns/1ps

module issue_register (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                flush_i,
  input  id_pkg::decoded_instr_t [id_pkg::NrIssuePorts-1:0] decoded_i,
  input  id_pkg::instr_t         [id_pkg::NrIssuePorts-1:0] orig_instr_i,
  input  logic                   [id_pkg::NrIssuePorts-1:0] fetch_valid_i,
  output logic                   [id_pkg::NrIssuePorts-1:0] fetch_ready_o,
  output id_pkg::issue_slot_t    [id_pkg::NrIssuePorts-1:0] slot_o,
  input  logic                   [id_pkg::NrIssuePorts-1:0] ack_i
);

  import id_pkg::*;

  issue_slot_t [NrIssuePorts-1:0] slot_d;
  issue_slot_t [NrIssuePorts-1:0] slot_q;
  issue_slot_t [NrIssuePorts-1:0] incoming;

  // Entry each fetch port would write into a slot
  for (genvar i = 0; i < NrIssuePorts; i++) begin : gen_incoming
    assign incoming[i] = '{valid: 1'b1, decoded: decoded_i[i], orig_instr: orig_instr_i[i]};
  end

  always_comb begin
    slot_d        = slot_q;
    fetch_ready_o = '0;

    // Acknowledged slots leave first
    for (int unsigned i = 0; i < NrIssuePorts; i++) begin
      if (ack_i[i]) begin
        slot_d[i].valid = 1'b0;
      end
    end

    // Slot 0 refills from slot 1 before taking anything from fetch
    if (!slot_d[0].valid) begin
      if (slot_d[1].valid) begin
        slot_d[0]       = slot_d[1];
        slot_d[1].valid = 1'b0;
      end else if (fetch_valid_i[0]) begin
        fetch_ready_o[0] = 1'b1;
        slot_d[0]        = incoming[0];
      end
    end

    // Slot 1 takes the oldest fetch entry not yet consumed
    if (!slot_d[1].valid) begin
      if (fetch_ready_o[0]) begin
        if (fetch_valid_i[1]) begin
          fetch_ready_o[1] = 1'b1;
          slot_d[1]        = incoming[1];
        end
      end else if (fetch_valid_i[0]) begin
        fetch_ready_o[0] = 1'b1;
        slot_d[1]        = incoming[0];
      end
    end

    // Flush drops held entries and whatever was taken this cycle
    if (flush_i) begin
      slot_d[0].valid = 1'b0;
      slot_d[1].valid = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q <= '0;
    end else begin
      slot_q <= slot_d;
    end
  end

  assign slot_o = slot_q;

  // --------------------------------------------------
  // Ordering checks
  // --------------------------------------------------
  // Port 1 is only ever taken alongside port 0
  a_ready_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_ready_o[1] |-> fetch_ready_o[0]);

  // Compaction keeps the older entry in slot 0
  a_slot_compact: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slot_q[1].valid |-> slot_q[0].valid);

  // Issue stage retires in order
  a_ack_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i[1] |-> ack_i[0]);

endmodule

// File: hw/instr_decoder.sv
// --------------------------------------------------
// RV32I instruction decoder
// Turns one 32-bit instruction into a decoded entry
// with unit, operation, registers and immediate
// --------------------------------------------------

`timescale 1ns/1ps

module instr_decoder (
  input  id_pkg::addr_t          pc_i,
  input  id_pkg::instr_t         instr_i,
  input  logic                   is_compressed_i,
  input  logic                   illegal_i,
  output id_pkg::decoded_instr_t entry_o
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  imm_t       imm_i_type;
  imm_t       imm_s_type;
  imm_t       imm_b_type;
  imm_t       imm_u_type;
  imm_t       imm_j_type;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  // Immediates of every format, sign extended
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  always_comb begin
    entry_o               = '0;
    entry_o.pc            = pc_i;
    entry_o.is_compressed = is_compressed_i;
    entry_o.fu            = FU_NONE;

    unique case (opcode)
      OpcodeLui: begin
        entry_o.fu  = FU_ALU;
        entry_o.rd  = instr_i[11:7];
        entry_o.imm = imm_u_type;
      end
      OpcodeAuipc: begin
        entry_o.fu  = FU_ALU;
        entry_o.rd  = instr_i[11:7];
        entry_o.imm = imm_u_type;
      end
      OpcodeJal: begin
        entry_o.fu           = FU_BRANCH;
        entry_o.rd           = instr_i[11:7];
        entry_o.imm          = imm_j_type;
        entry_o.is_ctrl_flow = 1'b1;
      end
      OpcodeJalr: begin
        entry_o.fu           = FU_BRANCH;
        entry_o.op           = {1'b0, funct3};
        entry_o.rd           = instr_i[11:7];
        entry_o.rs1          = instr_i[19:15];
        entry_o.imm          = imm_i_type;
        entry_o.is_ctrl_flow = 1'b1;
      end
      OpcodeBranch: begin
        entry_o.fu           = FU_BRANCH;
        entry_o.op           = {1'b0, funct3};
        entry_o.rs1          = instr_i[19:15];
        entry_o.rs2          = instr_i[24:20];
        entry_o.imm          = imm_b_type;
        entry_o.is_ctrl_flow = 1'b1;
      end
      OpcodeLoad: begin
        entry_o.fu  = FU_LOAD;
        entry_o.op  = {1'b0, funct3};
        entry_o.rd  = instr_i[11:7];
        entry_o.rs1 = instr_i[19:15];
        entry_o.imm = imm_i_type;
      end
      OpcodeStore: begin
        entry_o.fu  = FU_STORE;
        entry_o.op  = {1'b0, funct3};
        entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
        entry_o.imm = imm_s_type;
      end
      OpcodeOpImm: begin
        entry_o.fu  = FU_ALU;
        // Bit 30 picks SRAI over SRLI
        entry_o.op  = {(funct3 == 3'b101) & instr_i[30], funct3};
        entry_o.rd  = instr_i[11:7];
        entry_o.rs1 = instr_i[19:15];
        entry_o.imm = imm_i_type;
      end
      OpcodeOp: begin
        entry_o.fu  = FU_ALU;
        entry_o.op  = {instr_i[30], funct3};
        entry_o.rd  = instr_i[11:7];
        entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
      end
      default: begin
        entry_o.illegal = 1'b1;
      end
    endcase

    // Illegal entries keep only pc and the compressed flag
    if (illegal_i || entry_o.illegal) begin
      entry_o               = '0;
      entry_o.pc            = pc_i;
      entry_o.is_compressed = is_compressed_i;
      entry_o.fu            = FU_NONE;
      entry_o.illegal       = 1'b1;
    end
  end

endmodule

// File: hw/rvc_expander.sv
// --------------------------------------------------
// RVC expander
// Detects a compressed instruction and rewrites the
// supported subset into its 32-bit form
// --------------------------------------------------

`timescale 1ns/1ps

module rvc_expander (
  input  id_pkg::instr_t instr_i,
  output id_pkg::instr_t instr_o,
  output logic           is_compressed_o,
  output logic           illegal_o
);

  import id_pkg::*;

  cinstr_t   c;
  reg_addr_t rd_full;
  reg_addr_t rs2_full;
  reg_addr_t rs1_p;
  reg_addr_t rs2_p;

  assign c = instr_i[15:0];

  // Full register fields and the x8..x15 short forms
  assign rd_full  = c[11:7];
  assign rs2_full = c[6:2];
  assign rs1_p    = {2'b01, c[9:7]};
  assign rs2_p    = {2'b01, c[4:2]};

  assign is_compressed_o = (c[1:0] != 2'b11);

  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;

    if (is_compressed_o) begin
      // Anything outside the supported subset stays illegal
      illegal_o = 1'b1;

      unique case ({c[15:13], c[1:0]})
        // --------------------------------------------------
        // Quadrant 0
        // --------------------------------------------------
        // C.LW -> lw rd', uimm(rs1')
        5'b010_00: begin
          instr_o   = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_p, 3'b010, rs2_p,
                       OpcodeLoad};
          illegal_o = 1'b0;
        end
        // C.SW -> sw rs2', uimm(rs1')
        5'b110_00: begin
          instr_o   = {5'b0, c[5], c[12], rs2_p, rs1_p, 3'b010, c[11:10], c[6],
                       2'b00, OpcodeStore};
          illegal_o = 1'b0;
        end

        // --------------------------------------------------
        // Quadrant 1
        // --------------------------------------------------
        // C.ADDI -> addi rd, rd, imm (rd of zero is the NOP hint)
        5'b000_01: begin
          instr_o   = {{7{c[12]}}, c[6:2], rd_full, 3'b000, rd_full, OpcodeOpImm};
          illegal_o = 1'b0;
        end
        // C.LI -> addi rd, x0, imm
        5'b010_01: begin
          instr_o   = {{7{c[12]}}, c[6:2], 5'b0, 3'b000, rd_full, OpcodeOpImm};
          illegal_o = 1'b0;
        end
        // C.J -> jal x0, offset
        5'b101_01: begin
          instr_o   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                       c[12], {8{c[12]}}, 5'b0, OpcodeJal};
          illegal_o = 1'b0;
        end
        // C.BEQZ -> beq rs1', x0, offset
        5'b110_01: begin
          instr_o   = {{4{c[12]}}, c[6:5], c[2], 5'b0, rs1_p, 3'b000, c[11:10],
                       c[4:3], c[12], OpcodeBranch};
          illegal_o = 1'b0;
        end
        // C.BNEZ -> bne rs1', x0, offset
        5'b111_01: begin
          instr_o   = {{4{c[12]}}, c[6:5], c[2], 5'b0, rs1_p, 3'b001, c[11:10],
                       c[4:3], c[12], OpcodeBranch};
          illegal_o = 1'b0;
        end

        // --------------------------------------------------
        // Quadrant 2
        // --------------------------------------------------
        // C.MV and C.ADD (a zero rs2 field means JR, JALR or EBREAK)
        5'b100_10: begin
          if (rs2_full != '0) begin
            if (c[12]) begin
              instr_o = {7'b0, rs2_full, rd_full, 3'b000, rd_full, OpcodeOp};
            end else begin
              instr_o = {7'b0, rs2_full, 5'b0, 3'b000, rd_full, OpcodeOp};
            end
            illegal_o = 1'b0;
          end
        end

        default: begin
          illegal_o = 1'b1;
        end
      endcase
    end
  end

endmodule

// File: hw/id_pkg.sv
// --------------------------------------------------
// ID stage package
// Widths, field types, opcodes and the structs that
// carry fetch, decode and issue entries
// --------------------------------------------------

package id_pkg;

  localparam int unsigned NrIssuePorts = 2;
  localparam int unsigned XLEN         = 32;
  localparam int unsigned RegAddrW     = 5;

  // RV32I major opcodes
  localparam logic [6:0] OpcodeLui    = 7'b0110111;
  localparam logic [6:0] OpcodeAuipc  = 7'b0010111;
  localparam logic [6:0] OpcodeJal    = 7'b1101111;
  localparam logic [6:0] OpcodeJalr   = 7'b1100111;
  localparam logic [6:0] OpcodeBranch = 7'b1100011;
  localparam logic [6:0] OpcodeLoad   = 7'b0000011;
  localparam logic [6:0] OpcodeStore  = 7'b0100011;
  localparam logic [6:0] OpcodeOpImm  = 7'b0010011;
  localparam logic [6:0] OpcodeOp     = 7'b0110011;

  typedef logic [XLEN-1:0]     addr_t;
  typedef logic [31:0]         instr_t;
  typedef logic [15:0]         cinstr_t;
  typedef logic [RegAddrW-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]     imm_t;
  // funct3 in the low bits, instruction bit 30 on top where it matters
  typedef logic [3:0]          op_t;

  typedef enum logic [2:0] {
    FU_NONE   = 3'd0,
    FU_ALU    = 3'd1,
    FU_BRANCH = 3'd2,
    FU_LOAD   = 3'd3,
    FU_STORE  = 3'd4
  } fu_t;

  typedef struct packed {
    addr_t  address;
    instr_t instruction;
  } fetch_entry_t;

  typedef struct packed {
    addr_t     pc;
    fu_t       fu;
    op_t       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    imm_t      imm;
    logic      is_compressed;
    logic      illegal;
    logic      is_ctrl_flow;
  } decoded_instr_t;

  // One ID/issue pipeline slot
  typedef struct packed {
    logic           valid;
    decoded_instr_t decoded;
    instr_t         orig_instr;
  } issue_slot_t;

endpackage
